// ==== list.f ====
logic/console_bus_pkg.sv
logic/host_link_pkg.sv
logic/start_delay.sv
logic/host_port_decoder.sv
logic/console_bus_router.sv
logic/scratchpad_ram.sv
logic/ext_mem_wait_ctrl.sv
logic/ti_mem_subsystem.sv
tests/tb_clock_gen.sv
tests/ti_mem_assertions.sv
tests/tb_ti_mem_subsystem.sv

// ==== logic/console_bus_pkg.sv ====
// Console bus widths, cycle structs, region codes and the console memory map
`default_nettype none

package console_bus_pkg;

  localparam int CPU_ADDR_W = 23;   // Word address, A0 is not a byte select
  localparam int CPU_DATA_W = 16;
  localparam int PAD_ADDR_W = 9;    // 512 words = 1K bytes

  // One console bus cycle as the TI side presents it
  typedef struct packed {
    logic [CPU_ADDR_W-1:0] addr;
    logic                  we_n;    // Active low
    logic                  oe_n;    // Active low
    logic                  lb_n;    // Lower byte lane, active low
    logic                  ub_n;    // Upper byte lane, active low
    logic                  as;      // Address strobe
    logic [CPU_DATA_W-1:0] wdata;
  } cpu_bus_t;

  // Request towards the external memory controller
  typedef struct packed {
    logic [CPU_ADDR_W-1:0] addr;
    logic                  as;      // Delayed by one clock
    logic                  we_n;
    logic [CPU_DATA_W-1:0] wdata;
  } ext_mem_req_t;

  typedef enum logic [1:0] {
    REGION_UNMAPPED   = 2'd0,
    REGION_SCRATCHPAD = 2'd1,
    REGION_EXTERNAL   = 2'd2
  } mem_region_e;

  // ========================================
  // Memory map, word addresses as base and span (last - base)
  // ========================================
  localparam logic [CPU_ADDR_W-1:0] PAD_BASE = 23'h004000;
  localparam logic [CPU_ADDR_W-1:0] PAD_SPAN = CPU_ADDR_W'(2**PAD_ADDR_W - 1);

  localparam int EXT_AREAS = 5;
  // ROM, cart and high RAM, GROM bank, cartridges plus SAMS
  localparam logic [CPU_ADDR_W-1:0] EXT_BASE [EXT_AREAS] =
    '{23'h000000, 23'h005000, 23'h008000, 23'h018000, 23'h080000};
  localparam logic [CPU_ADDR_W-1:0] EXT_SPAN [EXT_AREAS] =
    '{23'h001FFF, 23'h002FFF, 23'h007FFF, 23'h007FFF, 23'h27FFFF};

endpackage

`default_nettype wire

// ==== logic/console_bus_router.sv ====
// Console bus router, memory map decode, scratchpad lane writes and read data select
`timescale 1ns/1ps
`default_nettype none

module console_bus_router
  import console_bus_pkg::*;
(
  input  wire                   clk,
  input  wire                   i_arst_n,
  input  wire cpu_bus_t         i_cpu,
  input  wire [CPU_DATA_W-1:0]  i_pad_rdata,
  input  wire [CPU_DATA_W-1:0]  i_ext_rdata,
  output mem_region_e           o_region,
  output logic [1:0]            o_pad_we,     // [1] upper lane, [0] lower lane
  output logic [CPU_DATA_W-1:0] o_cpu_rdata
);

  logic        pad_hit;
  logic        ext_hit;
  logic        pad_write;
  mem_region_e region_q;   // Lines up with RAM read latency

  // ========================================
  // Memory map decode
  // ========================================
  // Offset compare, wraps below base so one test per area
  assign pad_hit = ((i_cpu.addr - PAD_BASE) <= PAD_SPAN);

  always_comb
  begin
    ext_hit = 1'b0;
    for (int i = 0; i < EXT_AREAS; i++)
    begin
      if ((i_cpu.addr - EXT_BASE[i]) <= EXT_SPAN[i])
        ext_hit = 1'b1;
    end
  end

  always_comb
  begin
    if (pad_hit)
      o_region = REGION_SCRATCHPAD;
    else if (ext_hit)
      o_region = REGION_EXTERNAL;
    else
      o_region = REGION_UNMAPPED;
  end

  // Per-lane write enables
  assign pad_write   = (o_region == REGION_SCRATCHPAD) && !i_cpu.we_n;
  assign o_pad_we[0] = pad_write && !i_cpu.lb_n;
  assign o_pad_we[1] = pad_write && !i_cpu.ub_n;

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      region_q <= REGION_UNMAPPED;
    else
      region_q <= o_region;
  end

  // ========================================
  // Read data select
  // ========================================
  always_comb
  begin
    o_cpu_rdata = '0;                           // Unmapped reads give zero
    if (o_region == REGION_EXTERNAL)
      o_cpu_rdata = i_ext_rdata;                // Straight through
    else if ((o_region == REGION_SCRATCHPAD) && (region_q == REGION_SCRATCHPAD))
      o_cpu_rdata = i_pad_rdata;                // Valid one cycle after address
  end

endmodule

`default_nettype wire

// ==== logic/ext_mem_wait_ctrl.sv ====
// External memory wait-state control, delayed strobe and busy timeout counter
`timescale 1ns/1ps
`default_nettype none

module ext_mem_wait_ctrl
  import console_bus_pkg::*;
#(
  parameter int BUSY_TIMEOUT = 100
) (
  input  wire          clk,
  input  wire          i_arst_n,
  input  wire cpu_bus_t i_cpu,
  input  wire mem_region_e i_region,
  input  wire          i_ext_ack,          // One cycle done pulse
  output ext_mem_req_t o_ext,
  output logic         o_memory_busy,
  output logic         o_use_memory_busy
);

  localparam int CNT_W = $clog2(BUSY_TIMEOUT + 1);

  logic             ext_sel;
  logic             as_now;   // Qualified strobe, combinational
  logic             as_q;     // Delayed one clock toward controller
  logic [CNT_W-1:0] busy_cnt;

  assign ext_sel = (i_region == REGION_EXTERNAL);
  assign as_now  = i_cpu.as && ext_sel;

  // Console must wait while busy on these cycles
  assign o_use_memory_busy = ext_sel && (!i_cpu.we_n || !i_cpu.oe_n);

  // ========================================
  // Strobe delay and busy counter
  // ========================================
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      as_q     <= 1'b0;
      busy_cnt <= '0;
    end
    else
    begin
      as_q <= as_now;
      if (i_ext_ack)
        busy_cnt <= '0;                       // Done, release console
      else if (as_now)
        busy_cnt <= CNT_W'(BUSY_TIMEOUT);     // New strobe reloads
      else if (busy_cnt != '0)
        busy_cnt <= busy_cnt - CNT_W'(1);     // Timeout run-down
    end
  end

  assign o_memory_busy = (busy_cnt != '0);

  // Address, write and data pass straight on, held by console
  assign o_ext = '{addr: i_cpu.addr, as: as_q, we_n: i_cpu.we_n, wdata: i_cpu.wdata};

endmodule

`default_nettype wire

// ==== logic/host_link_pkg.sv ====
// Host port widths, host access and bootloader request structs, host command codes
`default_nettype none

package host_link_pkg;

  localparam int HOST_ADDR_W = 32;
  localparam int HOST_DATA_W = 8;

  localparam logic [7:0] CTRL_TAG = 8'hFF;  // Top byte of a control access
  localparam logic [3:0] RAM_TAG  = 4'h0;   // Top nibble of a RAM access

  // Already deserialized host access, pulses last one clock
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [HOST_ADDR_W-1:0] addr;
    logic [HOST_DATA_W-1:0] wdata;
  } host_access_t;

  // Level requests to the bootloader, held until acked
  typedef struct packed {
    logic [HOST_ADDR_W-1:0] addr;
    logic                   read_rq;
    logic                   write_rq;
    logic [HOST_DATA_W-1:0] wdata;
  } boot_req_t;

  typedef enum logic [1:0] {
    HOST_CMD_NONE    = 2'd0,
    HOST_CMD_CTRL_WR = 2'd1,
    HOST_CMD_RAM_RD  = 2'd2,
    HOST_CMD_RAM_WR  = 2'd3
  } host_cmd_e;

endpackage

`default_nettype wire

// ==== logic/host_port_decoder.sv ====
// Host port decoder, CPU control register and bootloader read/write requests
`timescale 1ns/1ps
`default_nettype none

module host_port_decoder
  import host_link_pkg::*;
(
  input  wire                    clk,
  input  wire                    i_arst_n,
  input  wire host_access_t      i_host,
  input  wire                    i_boot_read_ack,
  input  wire                    i_boot_write_ack,
  input  wire [HOST_DATA_W-1:0]  i_boot_rdata,
  output logic [7:0]             o_cpu_control,
  output boot_req_t              o_boot,
  output logic [HOST_DATA_W-1:0] o_host_rdata
);

  host_cmd_e              cmd;
  logic [HOST_ADDR_W-1:0] boot_addr;
  logic [HOST_DATA_W-1:0] boot_wdata;
  logic                   read_rq;
  logic                   write_rq;

  // ========================================
  // Access classification
  // ========================================
  always_comb
  begin
    cmd = HOST_CMD_NONE;
    if (i_host.wr && (i_host.addr[HOST_ADDR_W-1 -: 8] == CTRL_TAG))
    begin
      cmd = HOST_CMD_CTRL_WR;                 // Reads of control space ignored
    end
    else if (i_host.addr[HOST_ADDR_W-1 -: 4] == RAM_TAG)
    begin
      if (i_host.rd)
        cmd = HOST_CMD_RAM_RD;
      else if (i_host.wr)
        cmd = HOST_CMD_RAM_WR;
    end
  end

  // CPU control register
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_cpu_control <= '0;
    else if (cmd == HOST_CMD_CTRL_WR)
      o_cpu_control <= i_host.wdata;
  end

  // ========================================
  // Bootloader requests
  // ========================================
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      read_rq  <= 1'b0;
      write_rq <= 1'b0;
    end
    else
    begin
      // Ack wins over a new request in the same cycle
      if (i_boot_read_ack)
        read_rq <= 1'b0;
      else if (cmd == HOST_CMD_RAM_RD)
        read_rq <= 1'b1;

      if (i_boot_write_ack)
        write_rq <= 1'b0;
      else if (cmd == HOST_CMD_RAM_WR)
        write_rq <= 1'b1;
    end
  end

  // Address, write data and read data captures
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      boot_addr    <= '0;
      boot_wdata   <= '0;
      o_host_rdata <= '0;
    end
    else
    begin
      if ((cmd == HOST_CMD_RAM_RD) || (cmd == HOST_CMD_RAM_WR))
        boot_addr <= i_host.addr;
      if (cmd == HOST_CMD_RAM_WR)
        boot_wdata <= i_host.wdata;
      if (i_boot_read_ack)
        o_host_rdata <= i_boot_rdata;       // Byte back to host
    end
  end

  assign o_boot = '{addr: boot_addr, read_rq: read_rq, write_rq: write_rq, wdata: boot_wdata};

endmodule

`default_nettype wire

// ==== logic/scratchpad_ram.sv ====
// Scratchpad RAM, 512 words of two independently written byte lanes
`timescale 1ns/1ps
`default_nettype none

module scratchpad_ram
  import console_bus_pkg::*;
(
  input  wire                   clk,
  input  wire [PAD_ADDR_W-1:0]  i_addr,
  input  wire [1:0]             i_we,       // Byte lane enables
  input  wire [CPU_DATA_W-1:0]  i_wdata,
  output logic [CPU_DATA_W-1:0] o_rdata
);

  localparam int DEPTH = 2**PAD_ADDR_W;

  logic [CPU_DATA_W-1:0] mem [DEPTH];   // Contents undefined at power-up

  always_ff @(posedge clk)
  begin
    if (i_we[0])
      mem[i_addr][7:0] <= i_wdata[7:0];     // Lower lane
    if (i_we[1])
      mem[i_addr][15:8] <= i_wdata[15:8];   // Upper lane
    o_rdata <= mem[i_addr];                 // Registered read, old data on write
  end

endmodule

`default_nettype wire

// ==== logic/start_delay.sv ====
// Start delay, releases the system reset after clock lock and a counter run-out
`timescale 1ns/1ps
`default_nettype none

module start_delay #(
  parameter int DELAY_BITS = 24
) (
  input  wire  clk,
  input  wire  i_arst_n,
  input  wire  i_clk_locked,
  input  wire  i_reset_btn_n,   // Reset button, active low
  output logic o_cpu_reset_n
);

  logic [DELAY_BITS-1:0] delay_cnt;
  logic                  delay_done;

  assign delay_done = delay_cnt[DELAY_BITS-1];  // Top bit ends the wait

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      delay_cnt     <= '0;
      o_cpu_reset_n <= 1'b0;
    end
    else
    begin
      o_cpu_reset_n <= i_reset_btn_n & delay_done;   // Button gates the release
      if (!i_clk_locked)
        delay_cnt <= '0;                             // Restart on lock loss
      else if (!delay_done)
        delay_cnt <= delay_cnt + DELAY_BITS'(1);     // Saturates at top bit
    end
  end

endmodule

`default_nettype wire

// ==== logic/ti_mem_subsystem.sv ====
// Memory subsystem top level of the TI-99/4A console, start delay, host port and memory map
`timescale 1ns/1ps
`default_nettype none

module ti_mem_subsystem
  import console_bus_pkg::*;
  import host_link_pkg::*;
#(
  parameter int DELAY_BITS   = 24,
  parameter int BUSY_TIMEOUT = 100
) (
  input  wire                    clk,
  input  wire                    i_arst_n,
  // Reset sources
  input  wire                    i_clk_locked,
  input  wire                    i_reset_btn_n,
  output logic                   o_cpu_reset_n,
  // Console bus
  input  wire cpu_bus_t          i_cpu,
  output logic [CPU_DATA_W-1:0]  o_cpu_rdata,
  output logic                   o_memory_busy,
  output logic                   o_use_memory_busy,
  // External memory
  output ext_mem_req_t           o_ext,
  input  wire [CPU_DATA_W-1:0]   i_ext_rdata,
  input  wire                    i_ext_ack,
  // Host port and bootloader
  input  wire host_access_t      i_host,
  output logic [7:0]             o_cpu_control,
  output logic [HOST_DATA_W-1:0] o_host_rdata,
  output boot_req_t              o_boot,
  input  wire                    i_boot_read_ack,
  input  wire                    i_boot_write_ack,
  input  wire [HOST_DATA_W-1:0]  i_boot_rdata
);

  mem_region_e           region;
  logic [1:0]            pad_we;
  logic [CPU_DATA_W-1:0] pad_rdata;

  // ========================================
  // Reset and host side
  // ========================================
  start_delay #(.DELAY_BITS(DELAY_BITS)) u_start_delay (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_clk_locked  (i_clk_locked),
    .i_reset_btn_n (i_reset_btn_n),
    .o_cpu_reset_n (o_cpu_reset_n)
  );

  host_port_decoder u_host_port_decoder (
    .clk              (clk),
    .i_arst_n         (i_arst_n),
    .i_host           (i_host),
    .i_boot_read_ack  (i_boot_read_ack),
    .i_boot_write_ack (i_boot_write_ack),
    .i_boot_rdata     (i_boot_rdata),
    .o_cpu_control    (o_cpu_control),
    .o_boot           (o_boot),
    .o_host_rdata     (o_host_rdata)
  );

  // ========================================
  // Console memory side
  // ========================================
  console_bus_router u_console_bus_router (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_cpu       (i_cpu),
    .i_pad_rdata (pad_rdata),
    .i_ext_rdata (i_ext_rdata),
    .o_region    (region),
    .o_pad_we    (pad_we),
    .o_cpu_rdata (o_cpu_rdata)
  );

  scratchpad_ram u_scratchpad_ram (
    .clk     (clk),
    .i_addr  (i_cpu.addr[PAD_ADDR_W-1:0]),   // Low word address bits
    .i_we    (pad_we),
    .i_wdata (i_cpu.wdata),
    .o_rdata (pad_rdata)
  );

  ext_mem_wait_ctrl #(.BUSY_TIMEOUT(BUSY_TIMEOUT)) u_ext_mem_wait_ctrl (
    .clk               (clk),
    .i_arst_n          (i_arst_n),
    .i_cpu             (i_cpu),
    .i_region          (region),
    .i_ext_ack         (i_ext_ack),
    .o_ext             (o_ext),
    .o_memory_busy     (o_memory_busy),
    .o_use_memory_busy (o_use_memory_busy)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ti_mem_subsystem -f list.f -o tb_sim

# Last command of the pipe decides the exit status
./obj_dir/tb_sim | tee /dev/stderr | grep "Verification passed" > /dev/null

// ==== tests/tb_clock_gen.sv ====
// Testbench clock source, free running square wave
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic o_clk
);

  initial
  begin
    o_clk = 1'b0;
    forever
      #(PERIOD_NS / 2) o_clk = ~o_clk;   // Half period per phase
  end

endmodule

`default_nettype wire

// ==== tests/tb_ti_mem_subsystem.sv ====
// Testbench for the memory subsystem, plays the TI side, external memory and bootloader
`timescale 1ns/1ps
`default_nettype none

module tb_ti_mem_subsystem
  import console_bus_pkg::*;
  import host_link_pkg::*;
();

  localparam int PERIOD_NS = 40;

  typedef struct packed {
    logic [7:0]  op;     // Opcode letter
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } test_vec_t;

  logic                   clk;
  logic                   i_arst_n;
  logic                   i_clk_locked;
  logic                   i_reset_btn_n;
  logic                   o_cpu_reset_n;
  cpu_bus_t               i_cpu;
  logic [CPU_DATA_W-1:0]  o_cpu_rdata;
  logic                   o_memory_busy;
  logic                   o_use_memory_busy;
  ext_mem_req_t           o_ext;
  logic [CPU_DATA_W-1:0]  i_ext_rdata;
  logic                   i_ext_ack;
  host_access_t           i_host;
  logic [7:0]             o_cpu_control;
  logic [HOST_DATA_W-1:0] o_host_rdata;
  boot_req_t              o_boot;
  logic                   i_boot_read_ack;
  logic                   i_boot_write_ack;
  logic [HOST_DATA_W-1:0] i_boot_rdata;

  int unsigned errors;
  int unsigned ack_delay;   // Ext model ack delay, 0 never acks
  logic [7:0]  boot_byte;   // Byte the bootloader agent answers with
  test_vec_t   vecs[$];

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS)) u_clock_gen (.o_clk(clk));

  ti_mem_subsystem #(.DELAY_BITS(5), .BUSY_TIMEOUT(20)) DUT (.*);

  // ========================================
  // Reference rules and reporting
  // ========================================
  // External ranges of the console memory map
  function automatic logic expansion_addr(input logic [CPU_ADDR_W-1:0] a);
    return (a <= 23'h001FFF) || ((a >= 23'h005000) && (a <= 23'h00FFFF)) ||
           ((a >= 23'h018000) && (a <= 23'h01FFFF)) ||
           ((a >= 23'h080000) && (a <= 23'h2FFFFF));
  endfunction

  function automatic logic [15:0] ext_word(input logic [CPU_ADDR_W-1:0] a);
    return a[15:0] ^ {a[22:16], 9'h000} ^ 16'h5A5A;   // Whole address folds in
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("ERR %s: expected %0h, actual %0h", name, exp, act);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure: %s", what);
  endtask

  // ========================================
  // One data-file operation
  // ========================================
  task automatic run_vec(input test_vec_t v);
    string name;
    logic  exp_strobe;
    int    cycles;
    name = $sformatf("%s@%0h", v.op, v.addr);
    exp_strobe = expansion_addr(v.addr[CPU_ADDR_W-1:0]);
    cycles = 0;
    @(negedge clk);
    case (v.op)
      "K":
      begin
        i_clk_locked = 1'b1;
        while (!o_cpu_reset_n && (cycles < 64))
        begin
          @(negedge clk);
          cycles++;
        end
        if (cycles != int'(v.exp))
          report_mismatch({name, " release"}, v.exp, 32'(cycles));
      end
      "B":
      begin
        i_reset_btn_n = v.data[0];
        @(negedge clk);
        if (o_cpu_reset_n !== v.exp[0])
          report_mismatch(name, v.exp, 32'(o_cpu_reset_n));
      end
      "U":
      begin
        i_cpu.addr = v.addr[CPU_ADDR_W-1:0];
        i_cpu.we_n = v.data[1];
        i_cpu.oe_n = v.data[0];
        @(negedge clk);                          // Combinational, settled by now
        if (o_use_memory_busy !== v.exp[0])
          report_mismatch({name, " use_busy"}, v.exp, 32'(o_use_memory_busy));
        i_cpu.we_n = 1'b1;
        i_cpu.oe_n = 1'b1;
      end
      "W", "l", "u", "R":
      begin
        ack_delay   = v.data[31:16];
        i_cpu.addr  = v.addr[CPU_ADDR_W-1:0];
        i_cpu.wdata = v.data[15:0];
        i_cpu.we_n  = (v.op == "R");
        i_cpu.oe_n  = (v.op != "R");
        i_cpu.lb_n  = (v.op == "u") || (v.op == "R");
        i_cpu.ub_n  = (v.op == "l") || (v.op == "R");
        i_cpu.as    = 1'b1;
        @(negedge clk);
        if (o_ext.as !== exp_strobe)
          report_mismatch({name, " strobe"}, 32'(exp_strobe), 32'(o_ext.as));
        if (exp_strobe && (o_ext.addr !== v.addr[CPU_ADDR_W-1:0]))
          report_mismatch({name, " ext addr"}, v.addr, 32'(o_ext.addr));
        if (exp_strobe && (o_ext.we_n !== (v.op == "R")))
          report_mismatch({name, " ext we_n"}, 32'(v.op == "R"), 32'(o_ext.we_n));
        if (exp_strobe && (o_ext.wdata !== v.data[15:0]))
          report_mismatch({name, " ext wdata"}, 32'(v.data[15:0]), 32'(o_ext.wdata));
        i_cpu.as   = 1'b0;
        i_cpu.we_n = 1'b1;
        i_cpu.lb_n = 1'b1;
        i_cpu.ub_n = 1'b1;
        while (o_memory_busy && (cycles < 64))   // Address and oe held while busy
        begin
          @(negedge clk);
          cycles++;
        end
        if (v.op == "R")
        begin
          if (o_cpu_rdata !== v.exp[15:0])
            report_mismatch(name, v.exp, 32'(o_cpu_rdata));
        end
        else if (cycles != int'(v.exp))
          report_mismatch({name, " busy"}, v.exp, 32'(cycles));
        i_cpu.oe_n = 1'b1;
      end
      "C", "H", "G":
      begin
        boot_byte    = v.data[7:0];
        i_host.addr  = v.addr;
        i_host.wdata = v.data[7:0];
        i_host.wr    = (v.op != "G");
        i_host.rd    = (v.op == "G");
        @(negedge clk);
        i_host.wr = 1'b0;
        i_host.rd = 1'b0;
        if (v.op == "C")
        begin
          if (o_cpu_control !== v.exp[7:0])
            report_mismatch(name, v.exp, 32'(o_cpu_control));
          if (o_boot.read_rq || o_boot.write_rq)
            report_failure({name, " raised a bootloader request"});
        end
        else if ((v.op == "H") && !v.exp[0])
        begin
          if (o_boot.write_rq !== 1'b0)
            report_mismatch({name, " write_rq"}, 32'd0, 32'(o_boot.write_rq));
        end
        else
        begin
          if ((v.op == "G" ? o_boot.read_rq : o_boot.write_rq) !== 1'b1)
            report_failure({name, " raised no bootloader request"});
          if (o_boot.addr !== v.addr)
            report_mismatch({name, " boot addr"}, v.addr, o_boot.addr);
          if ((v.op == "H") && (o_boot.wdata !== v.data[7:0]))
            report_mismatch({name, " boot wdata"}, v.data, 32'(o_boot.wdata));
          while ((o_boot.read_rq || o_boot.write_rq) && (cycles < 32))
          begin
            @(negedge clk);
            cycles++;
          end
          if (cycles >= 32)
            report_failure({name, " request stayed up after its ack"});
          if ((v.op == "G") && (o_host_rdata !== v.exp[7:0]))
            report_mismatch({name, " host rdata"}, v.exp, 32'(o_host_rdata));
        end
      end
      default:
        report_failure({name, " has an unknown opcode"});
    endcase
  endtask

  // ========================================
  // External memory and bootloader models
  // ========================================
  initial
  begin : ext_mem_model
    logic [CPU_ADDR_W-1:0] req_addr;
    i_ext_ack   = 1'b0;
    i_ext_rdata = '0;
    forever
    begin
      @(negedge clk);
      if (o_ext.as && (ack_delay != 0))
      begin
        req_addr = o_ext.addr;
        repeat (ack_delay - 1) @(negedge clk);
        i_ext_rdata = ext_word(req_addr);   // Data with the ack pulse
        i_ext_ack   = 1'b1;
        @(negedge clk);
        i_ext_ack = 1'b0;
      end
    end
  end

  initial
  begin : boot_agent
    void'($urandom(70368));
    i_boot_read_ack  = 1'b0;
    i_boot_write_ack = 1'b0;
    i_boot_rdata     = '0;
    forever
    begin
      @(negedge clk);
      if (o_boot.read_rq || o_boot.write_rq)
      begin
        repeat ($urandom_range(1, 3)) @(negedge clk);   // Random extra latency
        i_boot_rdata     = boot_byte;
        i_boot_read_ack  = o_boot.read_rq;
        i_boot_write_ack = o_boot.write_rq;
        @(negedge clk);
        i_boot_read_ack  = 1'b0;
        i_boot_write_ack = 1'b0;
      end
    end
  end

  // ========================================
  // Main sequence
  // ========================================
  initial
  begin : main
    int          fd;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    longint      watchdog_ns;
    errors        = 0;
    ack_delay     = 0;
    boot_byte     = '0;
    i_arst_n      = 1'b0;
    i_clk_locked  = 1'b0;
    i_reset_btn_n = 1'b1;
    i_host        = '0;
    i_cpu = '{addr: '0, we_n: 1'b1, oe_n: 1'b1, lb_n: 1'b1, ub_n: 1'b1, as: 1'b0,
              wdata: '0};
    fd = $fopen("tests/ti_mem_testdata.txt", "r");
    if (fd == 0)
      report_failure("test data file could not be opened");
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if ((line.len() > 1) && (line.getc(0) != "#"))    // Skip column notes
          if ($sscanf(line, "%c %h %h %h", op, addr, data, exp) == 4)
            vecs.push_back('{op: op, addr: addr, data: data, exp: exp});
      end
      $fclose(fd);
      if (vecs.size() == 0)
        report_failure("test data file holds no operations");
      watchdog_ns = longint'(16 + 80 * vecs.size()) * PERIOD_NS;   // Worst case per line
      fork
        begin
          #(watchdog_ns);
          $display("Watchdog expired before all operations finished");
          $display("Verification failed");
          $finish;
        end
      join_none
      repeat (16) @(posedge clk);
      @(negedge clk);
      i_arst_n = 1'b1;
      @(negedge clk);
      if ({o_cpu_reset_n, o_ext.as, o_memory_busy, o_boot.read_rq, o_boot.write_rq} !== 5'b0)
        report_mismatch("reset flags", 32'd0,
                        32'({o_cpu_reset_n, o_ext.as, o_memory_busy, o_boot.read_rq,
                             o_boot.write_rq}));
      foreach (vecs[i])
        run_vec(vecs[i]);
    end
    $display("Operations: %0d, errors: %0d", vecs.size(), errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/ti_mem_assertions.sv ====
// Concurrent checks on the external wait state, strobe qualification and bootloader requests
`timescale 1ns/1ps
`default_nettype none

module ti_mem_assertions
  import console_bus_pkg::*;
  import host_link_pkg::*;
(
  input wire               clk,
  input wire               i_arst_n,
  input wire mem_region_e  i_region,
  input wire ext_mem_req_t i_ext,
  input wire               i_ext_ack,
  input wire               i_memory_busy,
  input wire boot_req_t    i_boot,
  input wire               i_boot_read_ack,
  input wire               i_boot_write_ack
);

  // Ack clears the counter on its own edge
  busy_drops_after_ack: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_ext_ack |=> !i_memory_busy)
    else $error("Busy still set the cycle after an external ack");

  // Delayed strobe only while the held address decodes external
  strobe_only_external: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_ext.as |-> (i_region == REGION_EXTERNAL))
    else $error("External strobe raised outside the external region");

  read_rq_held: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_boot.read_rq && !i_boot_read_ack) |=> i_boot.read_rq)
    else $error("Read request dropped before its ack");

  write_rq_held: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_boot.write_rq && !i_boot_write_ack) |=> i_boot.write_rq)
    else $error("Write request dropped before its ack");

endmodule

// Top level sees both the wait-state block and the host decoder signals
bind ti_mem_subsystem ti_mem_assertions u_ti_mem_assertions (
  .clk              (clk),
  .i_arst_n         (i_arst_n),
  .i_region         (region),
  .i_ext            (o_ext),
  .i_ext_ack        (i_ext_ack),
  .i_memory_busy    (o_memory_busy),
  .i_boot           (o_boot),
  .i_boot_read_ack  (i_boot_read_ack),
  .i_boot_write_ack (i_boot_write_ack)
);

`default_nettype wire

// ==== tests/ti_mem_testdata.txt ====
# op addr data exp, hex. K lock, B button, l/u/W/R console, U {we_n,oe_n}, C/H/G host
# Console data is {ack delay, word}; l/u/W exp is busy cycles, R exp is the read word
K 0 0 11
B 0 0 0
B 0 1 1
l 4005 000012AB 0
u 4005 0000CD34 0
R 4005 0 CDAB
W 41FF 0000BEEF 0
R 41FF 0 BEEF
R 2000 0 0
R 300000 0 0
W 3000 00001111 0
W 0100 00031234 3
W 18010 00005555 14
R 5A00 00020000 005A
R 2FFFFF 00010000 FBA5
R 80000 00040000 4A5A
U 8000 3 0
U 8000 2 1
U 4010 1 0
U 0000 1 1
C FF000000 5A 5A
C 10000000 77 5A
H 10000020 99 0
H 00001234 3C 1
G 00000042 E7 E7
